//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sd_ctrl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/sd_card_model.sv
`timescale 1ns/1ps
`include "sd_defs.svh"

// spi mode sd card, answers the init commands and single block reads
module sd_card_model (
    input  logic       sd_clk,
    input  logic       sd_cs,
    input  logic       sd_mosi,
    input  logic [2:0] gap_len,   // 0xFF bytes before the data token
    output logic       sd_miso
);
    logic [47:0] frame      = '0;
    int          in_cnt     = 0;      // command bits received
    int          rise_cnt   = 0;      // sd_clk rises modulo one byte
    int          acmd41_cnt = 0;
    logic [7:0]  out_byte   = 8'hFF;
    logic        miso_q     = 1'b1;
    logic [7:0]  tx_q [$];            // bytes waiting to go out

    assign sd_miso = miso_q;

    // queue the answer to one complete command frame
    task automatic answer(input logic [5:0] idx, input logic [31:0] arg);
        int i;
        case (idx)
            6'd0: begin
                acmd41_cnt = 0;
                tx_q.push_back(8'h01);   // idle state
            end
            6'd8: begin
                tx_q.push_back(8'h01);   // R7, voltage and check pattern echoed
                tx_q.push_back(8'h00);
                tx_q.push_back(8'h00);
                tx_q.push_back(8'h01);
                tx_q.push_back(8'hAA);
            end
            6'd55: tx_q.push_back(8'h01);
            6'd41: begin
                acmd41_cnt = acmd41_cnt + 1;
                tx_q.push_back((acmd41_cnt > 3) ? 8'h00 : 8'h01);   // ready on 4th try
            end
            6'd17: begin
                tx_q.push_back(8'h00);
                repeat (gap_len) tx_q.push_back(8'hFF);
                tx_q.push_back(8'hFE);
                for (i = 0; i < `SD_BLOCK_BYTES; i++) begin
                    tx_q.push_back(arg[7:0] ^ 8'(i));   // byte rule of the sector
                end
                tx_q.push_back(8'hC3);   // crc bytes, never checked
                tx_q.push_back(8'h3C);
            end
            default: tx_q.push_back(8'h04);   // illegal command
        endcase
    endtask

    // ****************************************
    // decode on rise, answer on fall
    // ****************************************
    always @(sd_clk) begin
        if (sd_clk) begin
            rise_cnt = (rise_cnt + 1) % 8;
            if (!sd_cs && (in_cnt != 0 || !sd_mosi)) begin
                frame  = {frame[46:0], sd_mosi};
                in_cnt = in_cnt + 1;
                if (in_cnt == 48) begin
                    in_cnt = 0;
                    answer(frame[45:40], frame[39:8]);
                end
            end
        end else begin
            if (rise_cnt == 0) begin
                out_byte = 8'hFF;   // nothing queued
                if (tx_q.size() > 0) begin
                    out_byte = tx_q.pop_front();
                end
                miso_q = out_byte[7];
            end else begin
                miso_q = out_byte[7 - rise_cnt];
            end
        end
    end

endmodule

//--- bench/tb_sd_ctrl.sv
`timescale 1ns/1ps

module tb_sd_ctrl;
    import sd_pkg::*;

    localparam int INIT_LIMIT = 20000;   // clk_ref cycles
    localparam int READ_LIMIT = 20000;
    localparam int BUSY_LIMIT = 100;
    localparam int NUM_CASES  = 5;
    localparam int WORDS      = 256;
    localparam int MIN_IDLE   = 74;

    typedef struct packed {
        logic [31:0] sec;
        logic        inject;   // extra start halfway through the read
    } read_case_t;

    logic        clk_ref;
    logic        arst_n;
    logic        sd_miso;
    logic        sd_clk;
    logic        sd_cs;
    logic        sd_mosi;
    logic        rd_start_en;
    logic [31:0] rd_sec_addr;
    logic        rd_busy;
    logic        rd_val_en;
    sd_word_t    rd_val_data;
    logic        sd_init_done;
    logic [2:0]  gap_len      = 3'd0;

    read_case_t  cases [NUM_CASES];
    logic [31:0] lfsr         = 32'hb59a;
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          idle_clks    = 0;      // sd_clk rises with cs high before the first command
    int          idle_bad     = 0;      // cycles with a busy bus while no read runs
    int          stray_words  = 0;      // word strobes while no read runs
    logic        cmd_seen     = 1'b0;
    logic        prev_sclk    = 1'b0;
    logic        prev_mosi    = 1'b1;

    sd_ctrl_top sd_ctrl_top_inst (
        .clk_ref      (clk_ref),
        .arst_n       (arst_n),
        .sd_miso      (sd_miso),
        .sd_clk       (sd_clk),
        .sd_cs        (sd_cs),
        .sd_mosi      (sd_mosi),
        .rd_start_en  (rd_start_en),
        .rd_sec_addr  (rd_sec_addr),
        .rd_busy      (rd_busy),
        .rd_val_en    (rd_val_en),
        .rd_val_data  (rd_val_data),
        .sd_init_done (sd_init_done)
    );

    sd_card_model card_inst (
        .sd_clk  (sd_clk),
        .sd_cs   (sd_cs),
        .sd_mosi (sd_mosi),
        .gap_len (gap_len),
        .sd_miso (sd_miso)
    );

    initial begin
        clk_ref = 1'b0;
        forever #20 clk_ref = ~clk_ref;
    end

    // ****************************************
    // bus monitor, mid cycle
    // ****************************************
    always @(negedge clk_ref) begin
        if (arst_n) begin
            if (!cmd_seen && sd_cs && sd_clk && !prev_sclk) begin
                idle_clks <= idle_clks + 1;
            end
            if (!cmd_seen && !sd_cs && prev_mosi && !sd_mosi) begin
                cmd_seen <= 1'b1;   // start bit of the first command
            end
            if (sd_init_done && !rd_busy && (sd_cs !== 1'b1 || sd_clk !== 1'b0)) begin
                idle_bad <= idle_bad + 1;
            end
            if (sd_init_done && !rd_busy && rd_val_en !== 1'b0) begin
                stray_words <= stray_words + 1;
            end
            prev_sclk <= sd_clk;
            prev_mosi <= sd_mosi;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_gap(output logic [2:0] g);
        g = 3'd0;
        repeat (3) begin
            lfsr = lfsr_step(lfsr);
            g    = {g[1:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string name, input sd_word_t exp_w, input sd_word_t act_w);
        if (act_w !== exp_w) begin
            $display("Fail %s: expected %h, actual %h", name, exp_w, act_w);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp_n, act_n);
            errors++;
        end
    endtask

    task automatic check_at_least(input string name, input int min_n, input int act_n);
        if (act_n < min_n) begin
            $display("Fail %s: expected at least %0d, actual %0d", name, min_n, act_n);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_f, input logic act_f);
        if (act_f !== exp_f) begin
            $display("Fail %s: expected %b, actual %b", name, exp_f, act_f);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic pulse_start(input logic [31:0] sec);
        @(posedge clk_ref);
        rd_start_en <= 1'b1;
        rd_sec_addr <= sec;
        @(posedge clk_ref);
        rd_start_en <= 1'b0;
    endtask

    // waits for init done, watching for any read activity meanwhile
    task automatic wait_init(output logic ok, output logic early_act);
        int n;
        n         = 0;
        early_act = 1'b0;
        while (!sd_init_done && n < INIT_LIMIT) begin
            @(negedge clk_ref);
            if (rd_busy || rd_val_en) begin
                early_act = 1'b1;
            end
            n++;
        end
        ok = sd_init_done;
    endtask

    // ****************************************
    // one sector read from the table
    // ****************************************
    task automatic run_read(input int t, output logic ok);
        string      name;
        int         n;
        int         words;
        int         err0;
        logic       injected;
        logic [7:0] s;
        sd_word_t   exp_word;
        name     = $sformatf("read_%0d_sec_%h%s", t, cases[t].sec,
                             cases[t].inject ? "_extra_start" : "");
        err0     = errors;
        words    = 0;
        injected = 1'b0;
        s        = cases[t].sec[7:0];
        ok       = 1'b0;
        draw_gap(gap_len);
        pulse_start(cases[t].sec);
        n = 0;
        while (!rd_busy && n < BUSY_LIMIT) begin
            @(negedge clk_ref);
            n++;
        end
        if (!rd_busy) begin
            $display("%s: rd_busy did not rise after the start pulse", name);
            errors++;
        end else begin
            n = 0;
            while (rd_busy && n < READ_LIMIT) begin
                @(posedge clk_ref);
                rd_start_en <= 1'b0;
                if (cases[t].inject && !injected && words == WORDS / 2) begin
                    rd_start_en <= 1'b1;
                    rd_sec_addr <= ~cases[t].sec;   // other sector, must be ignored
                    injected = 1'b1;
                end
                @(negedge clk_ref);
                if (rd_val_en) begin
                    exp_word = {s ^ 8'(2 * words), s ^ 8'(2 * words + 1)};
                    check_word($sformatf("%s word %0d", name, words), exp_word, rd_val_data);
                    words++;
                end
                n++;
            end
            if (rd_busy) begin
                $display("%s: rd_busy still high after %0d cycles", name, READ_LIMIT);
                errors++;
            end else begin
                ok = 1'b1;
            end
            check_count($sformatf("%s word count", name), WORDS, words);
        end
        end_test(name, err0);
    endtask

    initial begin
        logic ok;
        logic early_act;
        int   err0;
        int   t;
        arst_n      <= 1'b0;
        rd_start_en <= 1'b0;
        rd_sec_addr <= 32'd0;
        cases[0] = '{sec: 32'h0000_0000, inject: 1'b0};
        cases[1] = '{sec: 32'h0000_00A5, inject: 1'b0};
        cases[2] = '{sec: 32'h1234_5678, inject: 1'b1};
        cases[3] = '{sec: 32'hFFFF_FFFF, inject: 1'b0};
        cases[4] = '{sec: 32'h0000_003C, inject: 1'b1};
        repeat (3) @(posedge clk_ref);
        arst_n <= 1'b1;

        pulse_start(32'h0000_0040);   // too early, card not ready
        err0 = errors;
        wait_init(ok, early_act);
        if (!ok) begin
            $display("init: sd_init_done did not rise within %0d cycles", INIT_LIMIT);
            errors++;
        end
        check_at_least("init idle clocks", MIN_IDLE, idle_clks);
        end_test("init", err0);
        err0 = errors;
        check_flag("early_start read activity", 1'b0, early_act);
        end_test("early_start", err0);

        if (ok) begin
            for (t = 0; t < NUM_CASES; t++) begin
                run_read(t, ok);
                if (!ok) begin
                    break;
                end
            end
        end
        err0 = errors;
        check_count("idle_bus busy cycles", 0, idle_bad);
        check_count("idle_bus word strobes", 0, stray_words);
        end_test("idle_bus", err0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- source/sd_cmd_if.sv
`timescale 1ns/1ps

// request and reply path between one sequencer and the spi phy
interface sd_cmd_if;
    import sd_pkg::*;

    logic    req;   // one cycle, op and cmd valid with it
    sd_op_t  op;
    sd_cmd_t cmd;   // only used for OP_CMD
    logic    done;  // one cycle at the end of the operation
    sd_r1_t  rx;    // valid with done

    // sequencer side
    modport seq (
        output req,
        output op,
        output cmd,
        input  done,
        input  rx
    );

    // phy side
    modport phy (
        input  req,
        input  op,
        input  cmd,
        output done,
        output rx
    );

endinterface

//--- source/sd_ctrl_top.sv
`timescale 1ns/1ps

module sd_ctrl_top (
    input  logic             clk_ref,
    input  logic             arst_n,
    // card pins
    input  logic             sd_miso,
    output logic             sd_clk,
    output logic             sd_cs,
    output logic             sd_mosi,
    // user read port
    input  logic             rd_start_en,
    input  logic [31:0]      rd_sec_addr,
    output logic             rd_busy,
    output logic             rd_val_en,
    output sd_pkg::sd_word_t rd_val_data,
    output logic             sd_init_done
);

    sd_cmd_if init_if ();   // init sequencer to phy
    sd_cmd_if read_if ();   // read sequencer to phy

    sd_spi_phy sd_spi_phy_inst (
        .clk_ref      (clk_ref),
        .arst_n       (arst_n),
        .sd_init_done (sd_init_done),
        .init_port    (init_if.phy),
        .read_port    (read_if.phy),
        .sd_miso      (sd_miso),
        .sd_clk       (sd_clk),
        .sd_cs        (sd_cs),
        .sd_mosi      (sd_mosi)
    );

    sd_init sd_init_inst (
        .clk_ref      (clk_ref),
        .arst_n       (arst_n),
        .phy_port     (init_if.seq),
        .sd_init_done (sd_init_done)
    );

    // starts before init done are dropped inside
    sd_read sd_read_inst (
        .clk_ref      (clk_ref),
        .arst_n       (arst_n),
        .sd_init_done (sd_init_done),
        .rd_start_en  (rd_start_en),
        .rd_sec_addr  (rd_sec_addr),
        .phy_port     (read_if.seq),
        .rd_busy      (rd_busy),
        .rd_val_en    (rd_val_en),
        .rd_val_data  (rd_val_data)
    );

endmodule

//--- source/sd_defs.svh
`ifndef SD_DEFS_SVH
`define SD_DEFS_SVH

// ****************************************
// spi clock division
// ****************************************
// clk_ref cycles per half period of sd_clk
`define SD_SLOW_DIV 4       // before init done, kept low for simulation
`define SD_FAST_DIV 1       // after init done

// ****************************************
// poll limits and sizes
// ****************************************
`define SD_R1_POLL 8        // bytes waited for an R1 that is not 0xFF
`define SD_ACMD41_TRIES 64  // CMD55/ACMD41 rounds before going back to CMD0
`define SD_TOKEN_POLL 64    // bytes waited for the 0xFE start token

// one sector
`define SD_BLOCK_BYTES 512

`endif

//--- source/sd_init.sv
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_init (
    input  logic  clk_ref,
    input  logic  arst_n,
    sd_cmd_if.seq phy_port,
    output logic  sd_init_done
);
    import sd_pkg::*;

    localparam int PWR_BYTES = 10;   // 80 idle clocks

    typedef enum logic [2:0] {
        ST_PWR,
        ST_CMD0,
        ST_CMD8,
        ST_R7,
        ST_CMD55,
        ST_ACMD41,
        ST_END,
        ST_DONE
    } init_state_t;

    init_state_t state;
    logic        pend;    // request out, waiting for done
    logic        req_q;
    logic [3:0]  cnt;
    logic [6:0]  tries;

    assign phy_port.req = req_q;

    // ****************************************
    // operation per state
    // ****************************************
    always_comb begin
        phy_port.op  = OP_CMD;
        phy_port.cmd = '{idx: 6'd0, arg: 32'd0, crc: 7'h4A};   // CMD0, crc 0x95
        case (state)
            ST_PWR, ST_END: phy_port.op = OP_DUMMY;
            ST_R7:          phy_port.op = OP_BYTE;   // trailing R7 bytes
            ST_CMD8:        phy_port.cmd = '{idx: 6'd8, arg: 32'h0000_01AA, crc: 7'h43};
            ST_CMD55:       phy_port.cmd = '{idx: 6'd55, arg: 32'd0, crc: 7'h32};
            ST_ACMD41:      phy_port.cmd = '{idx: 6'd41, arg: 32'h4000_0000, crc: 7'h3B};
            default: ;
        endcase
    end

    // ****************************************
    // sequence
    // ****************************************
    always_ff @(posedge clk_ref or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ST_PWR;
            pend         <= 1'b0;
            req_q        <= 1'b0;
            cnt          <= 4'd0;
            tries        <= 7'd0;
            sd_init_done <= 1'b0;
        end else begin
            req_q <= 1'b0;
            if (!pend && state != ST_DONE) begin
                req_q <= 1'b1;
                pend  <= 1'b1;
            end else if (phy_port.done) begin
                pend <= 1'b0;
                case (state)
                    ST_PWR: begin
                        if (cnt == 4'(PWR_BYTES - 1)) begin
                            cnt   <= 4'd0;
                            state <= ST_CMD0;
                        end else begin
                            cnt <= cnt + 4'd1;
                        end
                    end
                    ST_CMD0: if (phy_port.rx == 8'h01) state <= ST_CMD8;   // idle state
                    ST_CMD8: begin
                        cnt   <= 4'd0;
                        state <= (phy_port.rx == 8'h01) ? ST_R7 : ST_CMD0;
                    end
                    ST_R7: begin
                        if (cnt == 4'd3) begin
                            cnt   <= 4'd0;
                            tries <= 7'd0;
                            state <= ST_CMD55;
                        end else begin
                            cnt <= cnt + 4'd1;
                        end
                    end
                    ST_CMD55: state <= ST_ACMD41;
                    ST_ACMD41: begin
                        if (phy_port.rx == 8'h00) begin
                            state <= ST_END;                       // card ready
                        end else if (tries == 7'(`SD_ACMD41_TRIES - 1)) begin
                            state <= ST_CMD0;
                        end else begin
                            tries <= tries + 7'd1;
                            state <= ST_CMD55;
                        end
                    end
                    ST_END: begin
                        state        <= ST_DONE;   // cs already back high
                        sd_init_done <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- source/sd_pkg.sv
package sd_pkg;

    // ****************************************
    // command frame fields
    // ****************************************
    // start bits and stop bit are added by the phy, 48 bits on the wire
    typedef struct packed {
        logic [5:0]  idx;   // command index
        logic [31:0] arg;   // argument, msb first
        logic [6:0]  crc;   // crc7, only checked by the card in idle state
    } sd_cmd_t;

    // ****************************************
    // phy operations
    // ****************************************
    typedef enum logic [1:0] {
        OP_DUMMY = 2'd0,    // 8 clocks, cs high, mosi high
        OP_CMD   = 2'd1,    // command frame then R1 poll
        OP_BYTE  = 2'd2     // one 0xFF out with cs low, byte in
    } sd_op_t;

    // R1 or a plain received byte
    typedef logic [7:0] sd_r1_t;

    // user data word, first byte of a pair in the upper half
    typedef logic [15:0] sd_word_t;

endpackage

//--- source/sd_read.sv
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_read (
    input  logic             clk_ref,
    input  logic             arst_n,
    input  logic             sd_init_done,
    input  logic             rd_start_en,
    input  logic [31:0]      rd_sec_addr,
    sd_cmd_if.seq            phy_port,
    output logic             rd_busy,
    output logic             rd_val_en,
    output sd_pkg::sd_word_t rd_val_data
);
    import sd_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD17,
        ST_TOKEN,
        ST_DATA,
        ST_CRC,
        ST_END
    } read_state_t;

    read_state_t state;
    logic        pend;
    logic        req_q;
    logic        start_ok;
    logic [9:0]  cnt;        // poll, data or crc byte count
    logic [31:0] sec_addr;
    sd_r1_t      hi_byte;    // first byte of the pair

    assign start_ok     = rd_start_en & sd_init_done & ~rd_busy;
    assign phy_port.req = req_q;

    always_comb begin
        phy_port.op  = OP_BYTE;
        phy_port.cmd = '{idx: 6'd17, arg: sec_addr, crc: 7'h7F};   // crc ignored by now
        case (state)
            ST_CMD17: phy_port.op = OP_CMD;
            ST_END:   phy_port.op = OP_DUMMY;   // releases cs
            default: ;
        endcase
    end

    // ****************************************
    // read sequence
    // ****************************************
    always_ff @(posedge clk_ref or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            pend      <= 1'b0;
            req_q     <= 1'b0;
            cnt       <= 10'd0;
            rd_busy   <= 1'b0;
            rd_val_en <= 1'b0;
        end else begin
            req_q     <= 1'b0;
            rd_val_en <= 1'b0;
            if (state == ST_IDLE) begin
                if (start_ok) begin
                    rd_busy <= 1'b1;
                    state   <= ST_CMD17;
                end
            end else if (!pend) begin
                req_q <= 1'b1;
                pend  <= 1'b1;
            end else if (phy_port.done) begin
                pend <= 1'b0;
                case (state)
                    ST_CMD17: begin
                        cnt   <= 10'd0;
                        state <= (phy_port.rx == 8'h00) ? ST_TOKEN : ST_END;
                    end
                    ST_TOKEN: begin
                        if (phy_port.rx == 8'hFE) begin
                            cnt   <= 10'd0;
                            state <= ST_DATA;
                        end else if (cnt == 10'(`SD_TOKEN_POLL - 1)) begin
                            state <= ST_END;   // no token, give up
                        end else begin
                            cnt <= cnt + 10'd1;
                        end
                    end
                    ST_DATA: begin
                        rd_val_en <= cnt[0];   // second byte completes a word
                        if (cnt == 10'(`SD_BLOCK_BYTES - 1)) begin
                            cnt   <= 10'd0;
                            state <= ST_CRC;
                        end else begin
                            cnt <= cnt + 10'd1;
                        end
                    end
                    ST_CRC: begin
                        if (cnt == 10'd1) begin
                            state <= ST_END;
                        end else begin
                            cnt <= cnt + 10'd1;
                        end
                    end
                    ST_END: begin
                        rd_busy <= 1'b0;
                        state   <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // ****************************************
    // address latch and word assembly
    // ****************************************
    always_ff @(posedge clk_ref) begin
        if (start_ok) begin
            sec_addr <= rd_sec_addr;
        end
        if (phy_port.done && state == ST_DATA) begin
            if (!cnt[0]) begin
                hi_byte <= phy_port.rx;
            end else begin
                rd_val_data <= {hi_byte, phy_port.rx};
            end
        end
    end

endmodule

//--- source/sd_spi_phy.sv
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_spi_phy (
    input  logic  clk_ref,
    input  logic  arst_n,
    input  logic  sd_init_done,
    sd_cmd_if.phy init_port,
    sd_cmd_if.phy read_port,
    input  logic  sd_miso,
    output logic  sd_clk,
    output logic  sd_cs,
    output logic  sd_mosi
);
    import sd_pkg::*;

    localparam int FRAME_BYTES = 6;
    localparam int LAST_POLL   = FRAME_BYTES + `SD_R1_POLL - 1;   // index of last R1 poll byte

    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } phy_state_t;

    phy_state_t  state;
    logic        req;
    sd_op_t      op;
    sd_op_t      op_q;       // operation in progress
    sd_cmd_t     cmd;
    logic [7:0]  div;
    logic [7:0]  div_cnt;    // half period counter
    logic [2:0]  bit_cnt;
    logic [5:0]  byte_cnt;   // byte index within the operation
    logic [47:0] tx_sr;      // msb is the bit on sd_mosi
    sd_r1_t      rx_sr;
    sd_r1_t      rx_q;
    logic        done_q;
    logic        half_end;
    logic        byte_end;
    logic        op_end;

    // ****************************************
    // port and divider select
    // ****************************************
    // init port until sd_init_done, read port after
    assign req = sd_init_done ? read_port.req : init_port.req;
    assign op  = sd_init_done ? read_port.op  : init_port.op;
    assign cmd = sd_init_done ? read_port.cmd : init_port.cmd;
    assign div = sd_init_done ? 8'(`SD_FAST_DIV) : 8'(`SD_SLOW_DIV);

    assign init_port.done = done_q & ~sd_init_done;
    assign read_port.done = done_q & sd_init_done;
    assign init_port.rx   = rx_q;
    assign read_port.rx   = rx_q;

    // ****************************************
    // byte timing
    // ****************************************
    assign half_end = (state == ST_SHIFT) && (div_cnt == div - 8'd1);
    assign byte_end = half_end && sd_clk && (bit_cnt == 3'd7);   // 8th falling edge

    // frame bytes never end a command, poll bytes end it on a real R1 or at the limit
    always_comb begin
        if (op_q != OP_CMD) begin
            op_end = 1'b1;
        end else begin
            op_end = (byte_cnt >= 6'(FRAME_BYTES)) &&
                     ((rx_sr != 8'hFF) || (byte_cnt == 6'(LAST_POLL)));
        end
    end

    // ****************************************
    // shifter and pins
    // ****************************************
    always_ff @(posedge clk_ref or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            op_q     <= OP_DUMMY;
            div_cnt  <= 8'd0;
            bit_cnt  <= 3'd0;
            byte_cnt <= 6'd0;
            tx_sr    <= '1;
            rx_sr    <= 8'hFF;
            rx_q     <= 8'hFF;
            done_q   <= 1'b0;
            sd_clk   <= 1'b0;
            sd_cs    <= 1'b1;
            sd_mosi  <= 1'b1;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        op_q     <= op;
                        div_cnt  <= 8'd0;
                        bit_cnt  <= 3'd0;
                        byte_cnt <= 6'd0;
                        state    <= ST_SHIFT;
                        if (op == OP_CMD) begin
                            tx_sr   <= {2'b01, cmd.idx, cmd.arg, cmd.crc, 1'b1};
                            sd_mosi <= 1'b0;                // start bit
                            sd_cs   <= 1'b0;
                        end else begin
                            tx_sr   <= '1;
                            sd_mosi <= 1'b1;
                            sd_cs   <= (op == OP_DUMMY);    // byte reads keep cs low
                        end
                    end
                end
                ST_SHIFT: begin
                    if (half_end) begin
                        div_cnt <= 8'd0;
                        sd_clk  <= ~sd_clk;
                        if (!sd_clk) begin
                            rx_sr <= {rx_sr[6:0], sd_miso};   // rising edge, sample
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                            tx_sr   <= {tx_sr[46:0], 1'b1};   // falling edge, next bit out
                            sd_mosi <= tx_sr[46];
                        end
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                    if (byte_end) begin
                        if (op_end) begin
                            state  <= ST_IDLE;
                            done_q <= 1'b1;
                            rx_q   <= rx_sr;
                        end else begin
                            byte_cnt <= byte_cnt + 6'd1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- vlog.f
+incdir+source
source/sd_pkg.sv
source/sd_cmd_if.sv
source/sd_spi_phy.sv
source/sd_init.sv
source/sd_read.sv
source/sd_ctrl_top.sv
bench/sd_card_model.sv
bench/tb_sd_ctrl.sv
